/* src/mipsPkg.sv */
package mipsPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 32;

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;
	typedef logic [dataWidth-1:0] instr_t;

	localparam word_t resetPc = 32'h0;

	// primary opcodes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti = 6'h0a;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opXori = 6'h0e;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	// special funct codes
	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnSrl = 6'h02;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

	// operand source selects for EX
	localparam logic [1:0] fwdRf = 2'd0;
	localparam logic [1:0] fwdMem = 2'd1;
	localparam logic [1:0] fwdWb = 2'd2;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluLui
	} aluOp_t;

	typedef enum logic {alu, mem} wbSel_t;

	typedef enum logic [1:0] {seq, branch, jump} nextPc_t;

	typedef struct packed {
		word_t pc;
		aluOp_t aluOp;
		logic useImm;
		logic [4:0] shamt;
		word_t rsData;
		word_t rtData;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t dest;
		word_t imm;
		logic regWe;
		logic memRd;
		logic memWe;
		wbSel_t wbSel;
	} idEx_t;

	typedef struct packed {
		word_t pc;
		word_t aluResult;
		word_t storeData;
		regAddr_t dest;
		logic regWe;
		logic memRd;
		logic memWe;
		wbSel_t wbSel;
	} exMem_t;

	typedef struct packed {
		word_t pc;
		word_t result;
		regAddr_t dest;
		logic regWe;
	} memWb_t;

	typedef struct packed {
		word_t pc;
		logic rfWe;
		regAddr_t rfNum;
		word_t rfData;
	} debugWb_t;

endpackage

/* src/mipsFetch.sv */
`timescale 1ns/100ps

module mipsFetch (
	input  logic            clk,
	input  logic            rst,
	input  logic            stall,
	input  mipsPkg::word_t  nextPc,
	input  mipsPkg::instr_t instr,
	output mipsPkg::word_t  pc,
	output mipsPkg::word_t  idPc,
	output mipsPkg::instr_t idInstr
);

	// sll r0,r0,0
	localparam mipsPkg::instr_t nopInstr = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= mipsPkg::resetPc;
		end else if (!stall) begin
			pc <= nextPc;
		end
	end

	// IF/ID, holds while decode is interlocked
	always_ff @(posedge clk) begin
		if (rst) begin
			idPc <= mipsPkg::resetPc;
			idInstr <= nopInstr;
		end else if (!stall) begin
			idPc <= pc;
			idInstr <= instr;
		end
	end

endmodule

/* src/mipsRegFile.sv */
`timescale 1ns/100ps

module mipsRegFile (
	input  logic              clk,
	input  logic              rst,
	input  mipsPkg::regAddr_t rs,
	input  mipsPkg::regAddr_t rt,
	input  mipsPkg::regAddr_t wrAddr,
	input  mipsPkg::word_t    wrData,
	input  logic              wrEn,
	output mipsPkg::word_t    rsData,
	output mipsPkg::word_t    rtData
);

	mipsPkg::word_t regs [mipsPkg::regCount];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < mipsPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// WB write seen by ID in the same cycle
	assign rsData = (rs == '0) ? '0 : (wrEn && wrAddr == rs) ? wrData : regs[rs];
	assign rtData = (rt == '0) ? '0 : (wrEn && wrAddr == rt) ? wrData : regs[rt];

endmodule

/* src/mipsDecode.sv */
`timescale 1ns/100ps

module mipsDecode (
	input  logic            clk,
	input  logic            rst,
	input  logic            stall,
	input  mipsPkg::word_t  pc,
	input  mipsPkg::word_t  idPc,
	input  mipsPkg::instr_t idInstr,
	input  mipsPkg::word_t  rsData,
	input  mipsPkg::word_t  rtData,
	input  mipsPkg::word_t  memFwd,
	input  logic            fwdBrA,
	input  logic            fwdBrB,
	output mipsPkg::word_t  nextPc,
	output mipsPkg::idEx_t  idEx,
	output logic            usesRs,
	output logic            usesRt,
	output logic            isBranch
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [15:0] imm16;
	mipsPkg::regAddr_t rs;
	mipsPkg::regAddr_t rt;
	mipsPkg::regAddr_t rd;
	mipsPkg::word_t immExt;
	mipsPkg::word_t cmpA;
	mipsPkg::word_t cmpB;
	mipsPkg::nextPc_t pcSel;
	mipsPkg::idEx_t dec;
	logic zeroExt;
	logic destRd;
	logic writes;

	assign opcode = idInstr[31:26];
	assign rs = idInstr[25:21];
	assign rt = idInstr[20:16];
	assign rd = idInstr[15:11];
	assign funct = idInstr[5:0];
	assign imm16 = idInstr[15:0];

	// logical ops and lui take the immediate unsigned
	assign zeroExt = opcode inside {mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori,
		mipsPkg::opLui};
	assign immExt = zeroExt ? {16'h0, imm16} : {{16{imm16[15]}}, imm16};

	assign cmpA = fwdBrA ? memFwd : rsData;
	assign cmpB = fwdBrB ? memFwd : rtData;

	always_comb begin
		dec = '0;
		dec.pc = idPc;
		dec.shamt = idInstr[10:6];
		dec.rsData = rsData;
		dec.rtData = rtData;
		dec.rs = rs;
		dec.rt = rt;
		dec.imm = immExt;
		usesRs = 1'b0;
		usesRt = 1'b0;
		isBranch = 1'b0;
		writes = 1'b0;
		destRd = 1'b0;
		pcSel = mipsPkg::seq;
		case (opcode)
			mipsPkg::opSpecial: begin
				destRd = 1'b1;
				writes = 1'b1;
				usesRs = 1'b1;
				usesRt = 1'b1;
				case (funct)
					mipsPkg::fnAddu: dec.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSubu: dec.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: dec.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr: dec.aluOp = mipsPkg::aluOr;
					mipsPkg::fnXor: dec.aluOp = mipsPkg::aluXor;
					mipsPkg::fnNor: dec.aluOp = mipsPkg::aluNor;
					mipsPkg::fnSlt: dec.aluOp = mipsPkg::aluSlt;
					mipsPkg::fnSltu: dec.aluOp = mipsPkg::aluSltu;
					mipsPkg::fnSll: begin
						dec.aluOp = mipsPkg::aluSll;
						usesRs = 1'b0;
					end
					mipsPkg::fnSrl: begin
						dec.aluOp = mipsPkg::aluSrl;
						usesRs = 1'b0;
					end
					default: begin
						writes = 1'b0;
						usesRs = 1'b0;
						usesRt = 1'b0;
					end
				endcase
			end
			mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opAndi, mipsPkg::opOri,
			mipsPkg::opXori: begin
				writes = 1'b1;
				usesRs = 1'b1;
				dec.useImm = 1'b1;
				case (opcode)
					mipsPkg::opSlti: dec.aluOp = mipsPkg::aluSlt;
					mipsPkg::opAndi: dec.aluOp = mipsPkg::aluAnd;
					mipsPkg::opOri: dec.aluOp = mipsPkg::aluOr;
					mipsPkg::opXori: dec.aluOp = mipsPkg::aluXor;
					default: dec.aluOp = mipsPkg::aluAdd;
				endcase
			end
			mipsPkg::opLui: begin
				writes = 1'b1;
				dec.useImm = 1'b1;
				dec.aluOp = mipsPkg::aluLui;
			end
			mipsPkg::opLw: begin
				writes = 1'b1;
				usesRs = 1'b1;
				dec.useImm = 1'b1;
				dec.memRd = 1'b1;
				dec.wbSel = mipsPkg::mem;
			end
			mipsPkg::opSw: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				dec.useImm = 1'b1;
				dec.memWe = 1'b1;
			end
			mipsPkg::opBeq, mipsPkg::opBne: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				isBranch = 1'b1;
				if ((cmpA == cmpB) == (opcode == mipsPkg::opBeq))
					pcSel = mipsPkg::branch;
			end
			mipsPkg::opJ: pcSel = mipsPkg::jump;
			default: ;
		endcase
		dec.dest = destRd ? rd : rt;
		dec.regWe = writes && (dec.dest != '0);
	end

	// pc already points at the delay slot
	always_comb begin
		case (pcSel)
			mipsPkg::branch: nextPc = pc + {immExt[29:0], 2'b00};
			mipsPkg::jump: nextPc = {pc[31:28], idInstr[25:0], 2'b00};
			default: nextPc = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || stall) begin
			idEx <= '0;
		end else begin
			idEx <= dec;
		end
	end

endmodule

/* src/mipsHazard.sv */
`timescale 1ns/100ps

module mipsHazard (
	input  mipsPkg::regAddr_t idRs,
	input  mipsPkg::regAddr_t idRt,
	input  logic              usesRs,
	input  logic              usesRt,
	input  logic              isBranch,
	input  mipsPkg::idEx_t    idEx,
	input  mipsPkg::exMem_t   exMem,
	input  mipsPkg::memWb_t   memWb,
	output logic              stall,
	output logic [1:0]        fwdA,
	output logic [1:0]        fwdB,
	output logic              fwdBrA,
	output logic              fwdBrB
);

	logic exHit;
	logic memLoadHit;

	// youngest producer wins
	function automatic logic [1:0] exSource(
		input mipsPkg::regAddr_t src,
		input mipsPkg::exMem_t m,
		input mipsPkg::memWb_t w
	);
		if (src == '0)
			return mipsPkg::fwdRf;
		if (m.regWe && m.dest == src)
			return mipsPkg::fwdMem;
		if (w.regWe && w.dest == src)
			return mipsPkg::fwdWb;
		return mipsPkg::fwdRf;
	endfunction

	assign fwdA = exSource(idEx.rs, exMem, memWb);
	assign fwdB = exSource(idEx.rt, exMem, memWb);

	// load data in MEM is not taken by the comparator
	assign fwdBrA = exMem.regWe && !exMem.memRd && exMem.dest != '0 && exMem.dest == idRs;
	assign fwdBrB = exMem.regWe && !exMem.memRd && exMem.dest != '0 && exMem.dest == idRt;

	assign exHit = idEx.regWe && idEx.dest != '0
		&& ((usesRs && idEx.dest == idRs) || (usesRt && idEx.dest == idRt));
	assign memLoadHit = exMem.regWe && exMem.memRd && exMem.dest != '0
		&& ((usesRs && exMem.dest == idRs) || (usesRt && exMem.dest == idRt));

	assign stall = (idEx.memRd && exHit) || (isBranch && (exHit || memLoadHit));

endmodule

/* src/mipsExecute.sv */
`timescale 1ns/100ps

module mipsExecute (
	input  logic            clk,
	input  logic            rst,
	input  mipsPkg::idEx_t  idEx,
	input  logic [1:0]      fwdA,
	input  logic [1:0]      fwdB,
	input  mipsPkg::word_t  memFwd,
	input  mipsPkg::word_t  wbFwd,
	output mipsPkg::exMem_t exMem
);

	mipsPkg::word_t opA;
	mipsPkg::word_t rtFwd;
	mipsPkg::word_t opB;
	mipsPkg::word_t aluResult;
	mipsPkg::exMem_t nextExMem;

	function automatic mipsPkg::word_t pickOperand(
		input logic [1:0] sel,
		input mipsPkg::word_t rfVal,
		input mipsPkg::word_t memVal,
		input mipsPkg::word_t wbVal
	);
		case (sel)
			mipsPkg::fwdMem: return memVal;
			mipsPkg::fwdWb: return wbVal;
			default: return rfVal;
		endcase
	endfunction

	assign opA = pickOperand(fwdA, idEx.rsData, memFwd, wbFwd);
	assign rtFwd = pickOperand(fwdB, idEx.rtData, memFwd, wbFwd);
	assign opB = idEx.useImm ? idEx.imm : rtFwd;

	always_comb begin
		case (idEx.aluOp)
			mipsPkg::aluAdd: aluResult = opA + opB;
			mipsPkg::aluSub: aluResult = opA - opB;
			mipsPkg::aluAnd: aluResult = opA & opB;
			mipsPkg::aluOr: aluResult = opA | opB;
			mipsPkg::aluXor: aluResult = opA ^ opB;
			mipsPkg::aluNor: aluResult = ~(opA | opB);
			mipsPkg::aluSlt: aluResult = mipsPkg::word_t'($signed(opA) < $signed(opB));
			mipsPkg::aluSltu: aluResult = mipsPkg::word_t'(opA < opB);
			// shifts act on rt
			mipsPkg::aluSll: aluResult = opB << idEx.shamt;
			mipsPkg::aluSrl: aluResult = opB >> idEx.shamt;
			mipsPkg::aluLui: aluResult = {opB[15:0], 16'h0};
			default: aluResult = '0;
		endcase
	end

	always_comb begin
		nextExMem.pc = idEx.pc;
		nextExMem.aluResult = aluResult;
		nextExMem.storeData = rtFwd;
		nextExMem.dest = idEx.regWe ? idEx.dest : '0;
		nextExMem.regWe = idEx.regWe;
		nextExMem.memRd = idEx.memRd;
		nextExMem.memWe = idEx.memWe;
		nextExMem.wbSel = idEx.wbSel;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exMem <= '0;
		end else begin
			exMem <= nextExMem;
		end
	end

endmodule

/* src/mipsMemWb.sv */
`timescale 1ns/100ps

module mipsMemWb (
	input  logic              clk,
	input  logic              rst,
	input  mipsPkg::exMem_t   exMem,
	input  mipsPkg::word_t    dataRdata,
	output mipsPkg::word_t    dataAddr,
	output mipsPkg::word_t    dataWdata,
	output logic              dataWe,
	output mipsPkg::word_t    memFwd,
	output mipsPkg::memWb_t   memWb,
	output mipsPkg::debugWb_t debugWb
);

	assign dataAddr = exMem.aluResult;
	assign dataWdata = exMem.storeData;
	assign dataWe = exMem.memWe;

	// read data is combinational, so loads resolve here
	assign memFwd = (exMem.wbSel == mipsPkg::mem) ? dataRdata : exMem.aluResult;

	always_ff @(posedge clk) begin
		if (rst) begin
			memWb <= '0;
		end else begin
			memWb.pc <= exMem.pc;
			memWb.result <= memFwd;
			memWb.dest <= exMem.dest;
			memWb.regWe <= exMem.regWe;
		end
	end

	assign debugWb.pc = memWb.pc;
	assign debugWb.rfWe = memWb.regWe;
	assign debugWb.rfNum = memWb.dest;
	assign debugWb.rfData = memWb.result;

endmodule

/* src/mipsCore.sv */
`timescale 1ns/100ps

module mipsCore (
	input  logic              clk,
	input  logic              rst,
	output mipsPkg::word_t    instrAddr,
	input  mipsPkg::instr_t   instr,
	output mipsPkg::word_t    dataAddr,
	output mipsPkg::word_t    dataWdata,
	output logic              dataWe,
	input  mipsPkg::word_t    dataRdata,
	output mipsPkg::debugWb_t debugWb
);

	mipsPkg::word_t nextPc;
	mipsPkg::word_t idPc;
	mipsPkg::instr_t idInstr;
	mipsPkg::word_t rsData;
	mipsPkg::word_t rtData;
	mipsPkg::word_t memFwd;
	mipsPkg::idEx_t idEx;
	mipsPkg::exMem_t exMem;
	mipsPkg::memWb_t memWb;
	logic stall;
	logic usesRs;
	logic usesRt;
	logic isBranch;
	logic [1:0] fwdA;
	logic [1:0] fwdB;
	logic fwdBrA;
	logic fwdBrB;

	mipsFetch fetch_i (
		.clk(clk), .rst(rst), .stall(stall), .nextPc(nextPc), .instr(instr),
		.pc(instrAddr), .idPc(idPc), .idInstr(idInstr)
	);

	mipsRegFile regFile_i (
		.clk(clk), .rst(rst), .rs(idInstr[25:21]), .rt(idInstr[20:16]),
		.wrAddr(memWb.dest), .wrData(memWb.result), .wrEn(memWb.regWe),
		.rsData(rsData), .rtData(rtData)
	);

	mipsDecode decode_i (
		.clk(clk), .rst(rst), .stall(stall), .pc(instrAddr), .idPc(idPc), .idInstr(idInstr),
		.rsData(rsData), .rtData(rtData), .memFwd(memFwd), .fwdBrA(fwdBrA), .fwdBrB(fwdBrB),
		.nextPc(nextPc), .idEx(idEx), .usesRs(usesRs), .usesRt(usesRt), .isBranch(isBranch)
	);

	mipsHazard hazard_i (
		.idRs(idInstr[25:21]), .idRt(idInstr[20:16]), .usesRs(usesRs), .usesRt(usesRt),
		.isBranch(isBranch), .idEx(idEx), .exMem(exMem), .memWb(memWb),
		.stall(stall), .fwdA(fwdA), .fwdB(fwdB), .fwdBrA(fwdBrA), .fwdBrB(fwdBrB)
	);

	mipsExecute execute_i (
		.clk(clk), .rst(rst), .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
		.memFwd(memFwd), .wbFwd(memWb.result), .exMem(exMem)
	);

	mipsMemWb memWb_i (
		.clk(clk), .rst(rst), .exMem(exMem), .dataRdata(dataRdata),
		.dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe),
		.memFwd(memFwd), .memWb(memWb), .debugWb(debugWb)
	);

endmodule

/* tests/mipsCore_sva.sv */
`timescale 1ns/100ps

module mipsCoreSva (
	input logic              clk,
	input logic              rst,
	input mipsPkg::word_t    instrAddr,
	input logic              stall,
	input mipsPkg::debugWb_t debugWb
);

	// writeback port is quiet right out of reset
	afterReset: assert property (@(posedge clk) rst |=> !debugWb.rfWe)
		else $error("debug writeback active in the cycle after reset");

	noZeroWrite: assert property (@(posedge clk) disable iff (rst)
		!(debugWb.rfWe && debugWb.rfNum == '0))
		else $error("debug writeback reports a write to r0");

	fetchAligned: assert property (@(posedge clk) disable iff (rst)
		instrAddr[1:0] == 2'b00)
		else $error("fetch address is not word aligned");

	// interlocked fetch keeps its address
	stallHold: assert property (@(posedge clk) disable iff (rst)
		stall |=> $stable(instrAddr))
		else $error("fetch address moved during a stall");

endmodule

bind mipsCore mipsCoreSva sva_i (
	.clk(clk),
	.rst(rst),
	.instrAddr(instrAddr),
	.stall(stall),
	.debugWb(debugWb)
);

/* tests/mipsTb.sv */
`timescale 1ns/100ps

module mipsTb;

	localparam int bodyLen = 200;
	localparam int progLen = bodyLen + 2;
	localparam int dataWords = 64;
	localparam int timeoutCycles = 10 * progLen;
	localparam logic [31:0] lfsrSeed = 32'h6da4cfb8;
	localparam mipsPkg::word_t endPc = 32'(bodyLen * 4);

	typedef struct packed {
		mipsPkg::word_t pc;
		mipsPkg::regAddr_t num;
		mipsPkg::word_t data;
	} commit_t;

	logic clk = 1'b0;
	logic rst = 1'b1;
	mipsPkg::word_t instrAddr;
	mipsPkg::instr_t instr;
	mipsPkg::word_t dataAddr;
	mipsPkg::word_t dataWdata;
	logic dataWe;
	mipsPkg::word_t dataRdata;
	mipsPkg::debugWb_t debugWb;

	mipsPkg::instr_t imem [256];
	mipsPkg::word_t dataMem [dataWords];
	mipsPkg::word_t modelMem [dataWords];
	commit_t expCommits [$];
	int expStoreCount = 0;
	logic [31:0] lfsrState;
	int commitIdx = 0;
	int storeIdx = 0;
	int cycles = 0;

	mipsCore dut_i (
		.clk(clk),
		.rst(rst),
		.instrAddr(instrAddr),
		.instr(instr),
		.dataAddr(dataAddr),
		.dataWdata(dataWdata),
		.dataWe(dataWe),
		.dataRdata(dataRdata),
		.debugWb(debugWb)
	);

	always #2 clk = ~clk;

	// both memories answer in the same cycle
	assign instr = imem[instrAddr[9:2]];
	assign dataRdata = dataMem[dataAddr[7:2]];

	task automatic stopWithFailure();
		$display("Verification failed");
		$fatal(1);
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic mipsPkg::regAddr_t randReg();
		logic [31:0] r;
		r = randBits(3);
		return {2'b00, r[2:0]};
	endfunction

	function automatic mipsPkg::word_t fillWord(input int i);
		return 32'h5a00_0000 ^ (i * 32'h9e37_79b9);
	endfunction

	function automatic mipsPkg::instr_t makeInstr(input logic [3:0] kind, input int idx);
		mipsPkg::regAddr_t rs;
		mipsPkg::regAddr_t rt;
		mipsPkg::regAddr_t rd;
		logic [31:0] r;
		logic [31:0] imm;
		logic [5:0] code;
		int off;
		int target;
		rs = randReg();
		rt = randReg();
		rd = randReg();
		imm = randBits(16);
		r = randBits(4);
		if (kind <= 4'd5) begin
			case (r % 10)
				0: code = mipsPkg::fnAddu;
				1: code = mipsPkg::fnSubu;
				2: code = mipsPkg::fnAnd;
				3: code = mipsPkg::fnOr;
				4: code = mipsPkg::fnXor;
				5: code = mipsPkg::fnNor;
				6: code = mipsPkg::fnSlt;
				7: code = mipsPkg::fnSltu;
				8: code = mipsPkg::fnSll;
				default: code = mipsPkg::fnSrl;
			endcase
			if (code == mipsPkg::fnSll || code == mipsPkg::fnSrl)
				return {mipsPkg::opSpecial, 5'd0, rt, rd, imm[4:0], code};
			return {mipsPkg::opSpecial, rs, rt, rd, 5'd0, code};
		end
		if (kind <= 4'd10) begin
			case (r % 6)
				0: code = mipsPkg::opAddiu;
				1: code = mipsPkg::opSlti;
				2: code = mipsPkg::opAndi;
				3: code = mipsPkg::opOri;
				4: code = mipsPkg::opXori;
				default: code = mipsPkg::opLui;
			endcase
			if (code == mipsPkg::opLui)
				return {code, 5'd0, rt, imm[15:0]};
			return {code, rs, rt, imm[15:0]};
		end
		// word index into the data array, base r0
		if (kind == 4'd11)
			return {mipsPkg::opLw, 5'd0, rt, 8'h00, imm[5:0], 2'b00};
		if (kind == 4'd12)
			return {mipsPkg::opSw, 5'd0, rt, 8'h00, imm[5:0], 2'b00};
		if (kind <= 4'd14) begin
			off = 1 + int'(r % 6);
			if (off > bodyLen - idx - 1)
				off = bodyLen - idx - 1;
			return {(kind == 4'd13) ? mipsPkg::opBeq : mipsPkg::opBne, rs, rt, 16'(off)};
		end
		target = idx + 2 + int'(r[2:0]);
		if (target > bodyLen)
			target = bodyLen;
		return {mipsPkg::opJ, 26'(target)};
	endfunction

	// no control transfer in a delay slot or right before the end loop
	task automatic buildProgram();
		logic [31:0] r;
		logic [3:0] kind;
		logic prevCtrl;
		prevCtrl = 1'b0;
		for (int i = 0; i < 256; i++) begin
			if (i == bodyLen) begin
				imem[i] = {mipsPkg::opJ, 26'(i)};
			end else if (i > bodyLen) begin
				imem[i] = '0;
			end else begin
				r = randBits(4);
				kind = r[3:0];
				if (kind >= 4'd13 && (prevCtrl || i == bodyLen - 1))
					kind = 4'd0;
				prevCtrl = (kind >= 4'd13);
				imem[i] = makeInstr(kind, i);
			end
		end
	endtask

	task automatic runModel();
		mipsPkg::word_t regs [mipsPkg::regCount];
		mipsPkg::word_t pc;
		mipsPkg::word_t npc;
		mipsPkg::word_t nnpc;
		mipsPkg::word_t a;
		mipsPkg::word_t b;
		mipsPkg::word_t simm;
		mipsPkg::word_t zimm;
		mipsPkg::word_t res;
		mipsPkg::word_t addr;
		mipsPkg::instr_t ins;
		mipsPkg::regAddr_t wr;
		logic doWrite;
		int steps;
		commit_t c;
		for (int i = 0; i < mipsPkg::regCount; i++) begin
			regs[i] = '0;
		end
		pc = mipsPkg::resetPc;
		npc = pc + 32'd4;
		steps = 0;
		while (pc != endPc && steps < 2 * progLen) begin
			ins = imem[pc[9:2]];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			zimm = {16'h0, ins[15:0]};
			nnpc = npc + 32'd4;
			wr = ins[20:16];
			doWrite = 1'b1;
			res = '0;
			addr = a + simm;
			case (ins[31:26])
				mipsPkg::opSpecial: begin
					wr = ins[15:11];
					case (ins[5:0])
						mipsPkg::fnAddu: res = a + b;
						mipsPkg::fnSubu: res = a - b;
						mipsPkg::fnAnd: res = a & b;
						mipsPkg::fnOr: res = a | b;
						mipsPkg::fnXor: res = a ^ b;
						mipsPkg::fnNor: res = ~(a | b);
						mipsPkg::fnSlt: res = {31'h0, $signed(a) < $signed(b)};
						mipsPkg::fnSltu: res = {31'h0, a < b};
						mipsPkg::fnSll: res = b << ins[10:6];
						mipsPkg::fnSrl: res = b >> ins[10:6];
						default: doWrite = 1'b0;
					endcase
				end
				mipsPkg::opAddiu: res = a + simm;
				mipsPkg::opSlti: res = {31'h0, $signed(a) < $signed(simm)};
				mipsPkg::opAndi: res = a & zimm;
				mipsPkg::opOri: res = a | zimm;
				mipsPkg::opXori: res = a ^ zimm;
				mipsPkg::opLui: res = {ins[15:0], 16'h0};
				mipsPkg::opLw: res = modelMem[addr[7:2]];
				mipsPkg::opSw: begin
					doWrite = 1'b0;
					modelMem[addr[7:2]] = b;
					expStoreCount++;
				end
				// targets are relative to the delay slot
				mipsPkg::opBeq: begin
					doWrite = 1'b0;
					if (a == b)
						nnpc = npc + {simm[29:0], 2'b00};
				end
				mipsPkg::opBne: begin
					doWrite = 1'b0;
					if (a != b)
						nnpc = npc + {simm[29:0], 2'b00};
				end
				mipsPkg::opJ: begin
					doWrite = 1'b0;
					nnpc = {npc[31:28], ins[25:0], 2'b00};
				end
				default: doWrite = 1'b0;
			endcase
			if (doWrite && wr != '0) begin
				regs[wr] = res;
				c.pc = pc;
				c.num = wr;
				c.data = res;
				expCommits.push_back(c);
			end
			pc = npc;
			npc = nnpc;
			steps++;
		end
	endtask

	// commit stream in model order
	always @(posedge clk) begin
		commit_t want;
		if (!rst && debugWb.rfWe) begin
			assert (commitIdx < expCommits.size())
			else begin
				$display("Register write reported after the last expected one, pc %h", debugWb.pc);
				stopWithFailure();
			end
			want = expCommits[commitIdx];
			assert (debugWb.pc == want.pc && debugWb.rfNum == want.num
				&& debugWb.rfData == want.data)
			else begin
				$display("Mismatch debugWb.pc: got %h expected %h", debugWb.pc, want.pc);
				$display("Mismatch debugWb.rfNum: got %h expected %h", debugWb.rfNum, want.num);
				$display("Mismatch debugWb.rfData: got %h expected %h", debugWb.rfData, want.data);
				stopWithFailure();
			end
			commitIdx++;
		end
	end

	// data memory write port, counted against the model's stores
	always @(posedge clk) begin
		if (!rst && dataWe) begin
			assert (storeIdx < expStoreCount)
			else begin
				$display("Store seen after the last expected one, address %h", dataAddr);
				stopWithFailure();
			end
			dataMem[dataAddr[7:2]] <= dataWdata;
			storeIdx++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		assert (cycles < timeoutCycles)
		else begin
			$display("Timeout after %0d cycles, the commit stream stalled", cycles);
			stopWithFailure();
		end
	end

	initial begin
		lfsrState = lfsrSeed;
		buildProgram();
		for (int i = 0; i < dataWords; i++) begin
			dataMem[i] <= fillWord(i);
			modelMem[i] = fillWord(i);
		end
		runModel();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		while (commitIdx < expCommits.size() || storeIdx < expStoreCount)
			@(negedge clk);
		for (int i = 0; i < dataWords; i++) begin
			assert (dataMem[i] == modelMem[i])
			else begin
				$display("Mismatch dataMem[%0d]: got %h expected %h", i, dataMem[i], modelMem[i]);
				stopWithFailure();
			end
		end
		$display("Verification passed");
		$finish;
	end

endmodule

/* vlog.f */
src/mipsPkg.sv
src/mipsFetch.sv
src/mipsRegFile.sv
src/mipsDecode.sv
src/mipsHazard.sv
src/mipsExecute.sv
src/mipsMemWb.sv
src/mipsCore.sv
tests/mipsCore_sva.sv
tests/mipsTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= mipsTb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Verification passed
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), look for the pass line in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
